/* hw/synth_config.svh */
`ifndef SYNTH_CONFIG_SVH
`define SYNTH_CONFIG_SVH

// Datapath width of samples, amplitude and envelope settings
`define SYNTH_SAMPLE_W 8

// APB address width
`define SYNTH_ADDR_W 4

// Last count of the idle and sustain hold timers
`define SYNTH_ENV_TIMER_MAX 255

// Last count of one square-wave half period
`define SYNTH_SQUARE_HALF 127

// Register map
`define SYNTH_ADDR_ENV 0
`define SYNTH_ADDR_CTRL 4

`endif

/* hw/synth_pkg.sv */
`include "synth_config.svh"

package synth_pkg;

    typedef logic [`SYNTH_SAMPLE_W-1:0] sample_t;       // One sample or amplitude value

    typedef enum logic [1:0] {
        WAVE_TRIANGLE = 2'd0,
        WAVE_SAW      = 2'd1,
        WAVE_SQUARE   = 2'd2,
        WAVE_MUTE     = 2'd3                            // Silence
    } wave_sel_e;

    typedef enum logic [2:0] {
        ADSR_IDLE,
        ADSR_ATTACK,
        ADSR_DECAY,
        ADSR_SUSTAIN,
        ADSR_RELEASE
    } adsr_state_e;

    // Envelope register, attack in the top byte
    typedef struct packed {
        sample_t attack;                                // Peak level of the ramp
        sample_t decay;                                 // Stored only
        sample_t sustain;                               // Hold level
        sample_t rel;                                   // Release setting, stored only
    } env_cfg_t;

    typedef struct packed {
        logic [29:0] reserved;                          // Always read as 0
        wave_sel_e   wave_sel;
    } ctrl_cfg_t;

    // One APB write word seen as either register layout
    typedef union packed {
        env_cfg_t  env;
        ctrl_cfg_t ctrl;
    } apb_wdata_u;

    typedef struct packed {
        logic                     psel;
        logic                     penable;
        logic                     pwrite;
        logic [`SYNTH_ADDR_W-1:0] paddr;
        apb_wdata_u               pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

endpackage

/* hw/synth_apb_regs.sv */
`include "synth_config.svh"

module synth_apb_regs (
    input  logic                 clk,
    input  logic                 reset,
    input  synth_pkg::apb_req_t  apb_req,
    output synth_pkg::apb_rsp_t  apb_rsp,
    output synth_pkg::env_cfg_t  env_cfg,
    output synth_pkg::wave_sel_e wave_sel
);

    logic                 access;                       // APB access phase
    logic                 hit_env;
    logic                 hit_ctrl;
    logic                 mapped;
    synth_pkg::env_cfg_t  env_reg;
    synth_pkg::wave_sel_e wave_reg;                     // Only stored field of the control register
    logic [31:0]          rdata;

    assign access = apb_req.psel & apb_req.penable;

    // Address decode
    assign hit_env  = (apb_req.paddr == `SYNTH_ADDR_W'(`SYNTH_ADDR_ENV));
    assign hit_ctrl = (apb_req.paddr == `SYNTH_ADDR_W'(`SYNTH_ADDR_CTRL));
    assign mapped   = hit_env | hit_ctrl;

    // Writes land on the access-phase edge
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            env_reg  <= '0;
            wave_reg <= synth_pkg::WAVE_TRIANGLE;       // Triangle by default
        end else if (access && apb_req.pwrite) begin
            if (hit_env) begin
                env_reg <= apb_req.pwdata.env;          // Word taken as envelope layout
            end
            if (hit_ctrl) begin
                wave_reg <= apb_req.pwdata.ctrl.wave_sel;   // Word taken as control layout
            end
        end
    end

    // Read mux, unmapped addresses return 0
    always_comb begin
        rdata = '0;
        if (hit_env) begin
            rdata = env_reg;
        end else if (hit_ctrl) begin
            rdata = 32'(wave_reg);                      // Reserved bits read as 0
        end
    end

    // Zero wait states, so pready follows the access phase directly
    always_comb begin
        apb_rsp.prdata  = rdata;
        apb_rsp.pready  = access;
        apb_rsp.pslverr = access & ~mapped;             // Error only in the access phase
    end

    assign env_cfg  = env_reg;
    assign wave_sel = wave_reg;

endmodule

/* hw/oscillator_bank.sv */
`include "synth_config.svh"

module oscillator_bank (
    input  logic                 clk,
    input  logic                 reset,
    input  synth_pkg::wave_sel_e wave_sel,
    output synth_pkg::sample_t   sample
);

    synth_pkg::sample_t saw_count;
    synth_pkg::sample_t tri_count;
    logic               tri_up;                         // Triangle direction
    synth_pkg::sample_t sq_count;                       // Square half-period counter
    logic               sq_level;
    synth_pkg::sample_t sq_wave;
    synth_pkg::sample_t next_sample;

    // Sawtooth wraps naturally at full scale
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            saw_count <= '0;
        end else begin
            saw_count <= saw_count + 1'b1;
        end
    end

    // Triangle turns around at each end, which holds the end value one cycle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tri_count <= '0;
            tri_up    <= 1'b1;
        end else if (tri_up) begin
            if (tri_count != '1) begin
                tri_count <= tri_count + 1'b1;
            end else begin
                tri_up <= 1'b0;
            end
        end else begin
            if (tri_count != '0) begin
                tri_count <= tri_count - 1'b1;
            end else begin
                tri_up <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sq_count <= '0;
            sq_level <= 1'b0;
        end else if (sq_count == `SYNTH_SAMPLE_W'(`SYNTH_SQUARE_HALF)) begin
            sq_count <= '0;
            sq_level <= ~sq_level;                      // Flip every 128 cycles
        end else begin
            sq_count <= sq_count + 1'b1;
        end
    end

    assign sq_wave = {`SYNTH_SAMPLE_W{sq_level}};       // Either 0 or full scale

    always_comb begin
        case (wave_sel)
            synth_pkg::WAVE_TRIANGLE: next_sample = tri_count;
            synth_pkg::WAVE_SAW:      next_sample = saw_count;
            synth_pkg::WAVE_SQUARE:   next_sample = sq_wave;
            default:                  next_sample = '0; // Mute
        endcase
    end

    // Output stage, one cycle behind the counters
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sample <= '0;
        end else begin
            sample <= next_sample;
        end
    end

endmodule

/* hw/adsr_vca.sv */
`include "synth_config.svh"

module adsr_vca (
    input  logic                clk,
    input  logic                reset,
    input  synth_pkg::env_cfg_t env_cfg,
    input  synth_pkg::sample_t  sample,
    output synth_pkg::sample_t  amplitude,
    output synth_pkg::sample_t  wave_out
);

    localparam int W = `SYNTH_SAMPLE_W;

    synth_pkg::adsr_state_e state;
    synth_pkg::sample_t     timer;                      // Shared by idle and sustain
    logic                   timer_done;
    logic [2*W-1:0]         product;

    assign timer_done = (timer == W'(`SYNTH_ENV_TIMER_MAX));

    // Self-retriggering envelope, one amplitude step per cycle while ramping
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= synth_pkg::ADSR_IDLE;
            amplitude <= '0;
            timer     <= '0;
        end else begin
            case (state)
                synth_pkg::ADSR_IDLE: begin
                    if (timer_done) begin
                        state <= synth_pkg::ADSR_ATTACK;
                        timer <= '0;
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                synth_pkg::ADSR_ATTACK: begin
                    if (amplitude < env_cfg.attack) begin
                        amplitude <= amplitude + 1'b1;
                    end else begin
                        state <= synth_pkg::ADSR_DECAY;     // Peak reached
                    end
                end
                synth_pkg::ADSR_DECAY: begin
                    if (amplitude > env_cfg.sustain) begin
                        amplitude <= amplitude - 1'b1;
                    end else begin
                        state <= synth_pkg::ADSR_SUSTAIN;
                    end
                end
                synth_pkg::ADSR_SUSTAIN: begin
                    amplitude <= env_cfg.sustain;           // Tracks register changes
                    if (timer_done) begin
                        state <= synth_pkg::ADSR_RELEASE;
                        timer <= '0;
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                synth_pkg::ADSR_RELEASE: begin
                    if (amplitude != '0) begin
                        amplitude <= amplitude - 1'b1;
                    end else begin
                        state <= synth_pkg::ADSR_IDLE;      // Starts the next round
                    end
                end
                default: begin
                    state <= synth_pkg::ADSR_IDLE;
                end
            endcase
        end
    end

    // VCA, full product scaled back to sample width
    // A zero factor already gives a zero product
    assign product  = sample * amplitude;
    assign wave_out = product[2*W-1:W];

endmodule

/* hw/synth_top.sv */
module synth_top (
    input  logic                clk,
    input  logic                reset,
    input  synth_pkg::apb_req_t apb_req,
    output synth_pkg::apb_rsp_t apb_rsp,
    output synth_pkg::sample_t  wave_out,
    output synth_pkg::sample_t  amplitude
);

    synth_pkg::env_cfg_t  env_cfg;
    synth_pkg::wave_sel_e wave_sel;
    synth_pkg::sample_t   sample;                       // Selected oscillator output

    // Control registers on APB
    synth_apb_regs synth_apb_regs_inst (
        .clk      (clk),
        .reset    (reset),
        .apb_req  (apb_req),
        .apb_rsp  (apb_rsp),
        .env_cfg  (env_cfg),
        .wave_sel (wave_sel)
    );

    oscillator_bank oscillator_bank_inst (
        .clk      (clk),
        .reset    (reset),
        .wave_sel (wave_sel),
        .sample   (sample)
    );

    // Envelope and amplitude scaling
    adsr_vca adsr_vca_inst (
        .clk       (clk),
        .reset     (reset),
        .env_cfg   (env_cfg),
        .sample    (sample),
        .amplitude (amplitude),
        .wave_out  (wave_out)
    );

endmodule

/* test/tb_clock_gen.sv */
module tb_clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;                             // Period of 100
        end
    end

    initial begin
        reset = 1'b1;
        repeat (4) @(posedge clk);
        reset <= 1'b0;                                  // Released on the fourth rising edge
    end

endmodule

/* test/synth_asserts.sv */
module synth_asserts (
    input logic                   clk,
    input logic                   reset,
    input synth_pkg::apb_req_t    apb_req,
    input synth_pkg::apb_rsp_t    apb_rsp,
    input synth_pkg::env_cfg_t    env_cfg,
    input synth_pkg::wave_sel_e   wave_sel,
    input synth_pkg::adsr_state_e env_state,
    input synth_pkg::sample_t     amplitude,
    input synth_pkg::sample_t     wave_out
);

    int assert_errors = 0;                              // Count of failed assertions

    // pready only in an access phase that follows a setup phase
    a_pready_access: assert property (@(posedge clk) disable iff (reset)
        apb_rsp.pready |-> (apb_req.psel && apb_req.penable
                            && $past(apb_req.psel && !apb_req.penable)))
    else begin
        assert_errors++;
        $error("pready high outside an APB access phase");
    end

    a_attack_peak: assert property (@(posedge clk) disable iff (reset)
        (env_state == synth_pkg::ADSR_ATTACK) |-> (amplitude <= env_cfg.attack))
    else begin
        assert_errors++;
        $error("amplitude above the attack setting during attack");
    end

    // Mute reaches the output one cycle later through the sample register
    a_mute_silent: assert property (@(posedge clk) disable iff (reset)
        (wave_sel == synth_pkg::WAVE_MUTE) |=> (wave_out == '0))
    else begin
        assert_errors++;
        $error("wave_out not silent with mute selected");
    end

endmodule

bind synth_top synth_asserts synth_asserts_inst (
    .clk       (clk),
    .reset     (reset),
    .apb_req   (apb_req),
    .apb_rsp   (apb_rsp),
    .env_cfg   (env_cfg),
    .wave_sel  (wave_sel),
    .env_state (adsr_vca_inst.state),
    .amplitude (amplitude),
    .wave_out  (wave_out)
);

/* test/synth_tb.sv */
`include "synth_config.svh"

module synth_tb;

    logic                clk;
    logic                reset;
    synth_pkg::apb_req_t apb_req;
    synth_pkg::apb_rsp_t apb_rsp;
    synth_pkg::sample_t  wave_out;
    synth_pkg::sample_t  amplitude;

    logic [31:0] vec_mem [0:255];                       // Four words per test step
    int          pass_count;
    int          fail_count;
    int          step_errors;

    tb_clock_gen clock_gen_inst (
        .clk   (clk),
        .reset (reset)
    );

    synth_top synth_top_inst (
        .clk       (clk),
        .reset     (reset),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .wave_out  (wave_out),
        .amplitude (amplitude)
    );

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("Mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
        step_errors++;
    endtask

    task automatic report_failure(input string what);
        $display("Error at %0t: %s", $time, what);
        step_errors++;
    endtask

    // One APB transfer, response sampled mid-cycle in the access phase
    task automatic apb_access(input logic is_write, input logic [31:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        int waited;
        @(posedge clk);
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= is_write;
        apb_req.paddr   <= addr[`SYNTH_ADDR_W-1:0];
        apb_req.pwdata  <= wdata;
        @(posedge clk);
        apb_req.penable <= 1'b1;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!apb_rsp.pready && waited < 16);
        if (!apb_rsp.pready) begin
            report_failure("APB slave never raised pready");
        end
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(posedge clk);
        apb_req.psel    <= 1'b0;
        apb_req.penable <= 1'b0;
    endtask

    task automatic wait_amplitude(input synth_pkg::sample_t target, input int limit);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (amplitude !== target && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (amplitude !== target) begin
            report_failure($sformatf("amplitude never reached %h in %0d cycles", target, limit));
        end
    endtask

    // Sorts wave_out samples into zero, the high level and anything else
    task automatic observe_wave(input int cycles, input synth_pkg::sample_t high,
                                output int n_zero, output int n_high, output int n_other,
                                output synth_pkg::sample_t peak);
        n_zero  = 0;
        n_high  = 0;
        n_other = 0;
        peak    = '0;
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            if (wave_out == 8'h00) begin
                n_zero++;
            end else if (wave_out == high) begin
                n_high++;
            end else begin
                n_other++;
            end
            if (wave_out > peak) begin
                peak = wave_out;
            end
        end
    endtask

    initial begin
        logic [31:0]        op;
        logic [31:0]        addr;
        logic [31:0]        data;
        logic [31:0]        expected;
        logic [31:0]        rdata;
        logic               err;
        logic               mapped;
        logic [7:0]         base;
        int                 step;
        int                 count;
        int                 n_zero;
        int                 n_high;
        int                 n_other;
        synth_pkg::sample_t max_seen;

        apb_req    = '0;
        pass_count = 0;
        fail_count = 0;
        $readmemh("test/synth_vectors.txt", vec_mem);

        count = 0;
        while (reset !== 1'b0 && count < 20) begin
            @(negedge clk);
            count++;
        end
        if (reset !== 1'b0) begin
            $display("Error: reset was never released");
            fail_count++;
        end

        step = 0;
        base = 8'd0;
        while (step < 64 && vec_mem[base] !== 32'h0 && !$isunknown(vec_mem[base])) begin
            op          = vec_mem[base];
            addr        = vec_mem[base + 8'd1];
            data        = vec_mem[base + 8'd2];
            expected    = vec_mem[base + 8'd3];
            step_errors = 0;
            case (op)
                1, 2: begin                             // Write or read
                    mapped = (addr == `SYNTH_ADDR_ENV) || (addr == `SYNTH_ADDR_CTRL);
                    apb_access(op == 1, addr, data, rdata, err);
                    if (err !== ~mapped) begin
                        report_mismatch("pslverr", 32'(~mapped), 32'(err));
                    end
                    if (op == 2 && mapped && rdata !== expected) begin
                        report_mismatch("prdata", expected, rdata);
                    end
                end
                3: begin
                    wait_amplitude(expected[7:0], int'(data));
                end
                4: begin                                // Release, then the idle gap
                    wait_amplitude(8'h00, int'(data));
                    count = 0;
                    while (amplitude == 8'h00 && count < int'(data)) begin
                        @(negedge clk);
                        count++;
                    end
                    if (amplitude == 8'h00) begin
                        report_failure("amplitude did not rise again after release");
                    end else if (count < int'(expected)) begin
                        report_failure($sformatf("envelope restarted after %0d idle cycles",
                                                 count));
                    end
                end
                5, 6, 7: begin                          // Square, mute, saw
                    observe_wave(int'(data), expected[7:0], n_zero, n_high, n_other, max_seen);
                    if (op == 5 && (n_other != 0 || n_zero == 0 || n_high == 0)) begin
                        report_failure($sformatf("square output had %0d zero, %0d high, %0d other",
                                                 n_zero, n_high, n_other));
                    end
                    if (op != 5 && max_seen !== expected[7:0]) begin
                        report_mismatch("wave_out peak", expected, 32'(max_seen));
                    end
                end
                8: begin
                    @(negedge clk);
                    if (amplitude !== expected[7:0]) begin
                        report_mismatch("amplitude", expected, 32'(amplitude));
                    end
                    if (wave_out !== expected[7:0]) begin
                        report_mismatch("wave_out", expected, 32'(wave_out));
                    end
                end
                default: begin
                    report_failure($sformatf("unknown operation code %0d", op));
                end
            endcase
            if (step_errors == 0) begin
                $display("Step %0d (op %0d) passed", step, op);
                pass_count++;
            end else begin
                $display("Step %0d (op %0d) failed with %0d errors", step, op, step_errors);
                fail_count++;
            end
            step++;
            base = base + 8'd4;
        end

        if (step == 0) begin
            $display("Error: no test steps were read from the vector file");
            fail_count++;
        end
        if (synth_top_inst.synth_asserts_inst.assert_errors != 0) begin
            $display("Error: %0d concurrent assertion failures",
                     synth_top_inst.synth_asserts_inst.assert_errors);
            fail_count++;
        end
        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* test/synth_vectors.txt */
// op addr data expected: 1 write, 2 read, 3 wait for amplitude, data is the timeout
// 4 release gap with minimum idle cycles, 5 square, 6 mute peak, 7 saw peak, 8 zero outputs
8 0 00000000 00000000
2 0 00000000 00000000
2 4 00000000 00000000
1 0 80114022 00000000
1 4 FFFFFFF6 00000000
2 0 00000000 80114022
2 4 00000000 00000002
1 8 DEADBEEF 00000000
2 8 00000000 00000000
2 0 00000000 80114022
2 4 00000000 00000002
3 0 000007D0 00000080
3 0 000001F4 00000040
5 0 000000C8 0000003F
4 0 000003E8 000000C8
1 4 00000003 00000000
3 0 000007D0 00000080
6 0 0000012C 00000000
1 4 00000001 00000000
3 0 000007D0 00000080
3 0 000001F4 00000040
7 0 0000012C 0000003F

/* files.f */
+incdir+hw
hw/synth_pkg.sv
hw/synth_apb_regs.sv
hw/oscillator_bank.sv
hw/adsr_vca.sv
hw/synth_top.sv
test/tb_clock_gen.sv
test/synth_asserts.sv
test/synth_tb.sv

/* Bender.yml */
package:
  name: synth_tone

sources:
  - include_dirs:
      - hw
    files:
      - hw/synth_pkg.sv
      - hw/synth_apb_regs.sv
      - hw/oscillator_bank.sv
      - hw/adsr_vca.sv
      - hw/synth_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - test/tb_clock_gen.sv
      - test/synth_asserts.sv
      - test/synth_tb.sv
